//--- vlog.f
link_pkg.sv
gtx_wrap.sv
link_reset_seq.sv
link_tx_framer.sv
link_rx_aligner.sv
link_rx_buffer.sv
link_top.sv
link_tb_clkgen.sv
link_checker.sv
link_tb.sv

//--- Makefile
TOP := link_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal +define+SIMULATE \
		-f vlog.f --top-module $(TOP) -o $(TOP)_sim

run: compile
	./obj_dir/$(TOP)_sim +verilator+error+limit+100 | tee run.log
	grep -q '>>> PASS' run.log

clean:
	rm -rf obj_dir run.log

//--- link_tb.sv
// link testbench with stimulus table, scoreboard queue, compare tasks, watchdog and summary
`timescale 1ns/10ps

module link_tb;

	typedef enum logic [1:0] {POP_ALWAYS, POP_NEVER, POP_THIRD} pop_e;

	localparam int N_TESTS   = 4;
	localparam int STALL_CYC = 50;   // ready low this long means receiver full
	localparam int UP_BOUND  = 600;  // bring-up limit incl. one align retry
	localparam int QUIET_CYC = 20;

	// one row per test with name, words accepted, first payload, pop pattern and reset flag
	string t_name [N_TESTS] = '{"stream_pop_always", "backpressure_no_pop",
		"credit_pop_third", "reset_mid_run"};
	int t_words [N_TESTS] = '{24, link_pkg::RX_DEPTH, 20, 16};
	logic [link_pkg::PAY_W-1:0] t_first [N_TESTS] = '{16'h1234, 16'hbeef, 16'h0f57, 16'h7e01};
	pop_e t_pop [N_TESTS] = '{POP_ALWAYS, POP_NEVER, POP_THIRD, POP_ALWAYS};
	bit   t_rst [N_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b1};

	logic                       clk;
	logic                       gen_rst;
	logic                       tb_rst;    // mid-run reset
	logic [link_pkg::PAY_W-1:0] tx_data;
	logic                       tx_valid;
	logic                       tx_ready;
	logic [link_pkg::PAY_W-1:0] rx_data;
	logic                       rx_valid;
	logic                       rx_pop;
	logic                       link_up;

	logic [link_pkg::PAY_W-1:0] exp_q [$];  // expected words in order
	logic [link_pkg::PAY_W-1:0] cur_pay;    // word offered until accepted
	int    seed = 32'h25a8;
	int    errs;
	int    accepted;
	int    popped;
	int    pass_cnt = 0;
	int    fail_cnt = 0;
	string cur_name;

	link_tb_clkgen u_clk (.clk_o (clk), .rst_o (gen_rst));

	link_top dut (
		.usrclk_i (clk), .rst_i (gen_rst || tb_rst),
		.tx_data_i (tx_data), .tx_valid_i (tx_valid), .rx_pop_i (rx_pop),
		.tx_ready_o (tx_ready), .rx_data_o (rx_data), .rx_valid_o (rx_valid),
		.link_up_o (link_up)
	);

	task automatic check_payload(input string what, input logic [link_pkg::PAY_W-1:0] exp_v,
		input logic [link_pkg::PAY_W-1:0] act_v);
		if (act_v !== exp_v) begin
			$display("Fail %s %s: expected %h actual %h", cur_name, what, exp_v, act_v);
			errs++;
		end
	endtask

	task automatic check_bit(input string what, input logic exp_v, input logic act_v);
		if (act_v !== exp_v) begin
			$display("Fail %s %s: expected %b actual %b", cur_name, what, exp_v, act_v);
			errs++;
		end
	endtask

	task automatic check_count(input string what, input int exp_v, input int act_v);
		if (act_v != exp_v) begin
			$display("Fail %s %s: expected %0d actual %0d", cur_name, what, exp_v, act_v);
			errs++;
		end
	endtask

	task automatic tick();
		@(posedge clk);
		#1;  // outputs settled and inputs change here
	endtask

	// offer and pop both take effect at the coming edge
	task automatic step(input bit offer, input bit pop_en);
		tx_valid = offer;
		tx_data  = cur_pay;
		rx_pop   = pop_en && rx_valid;
		if (offer && tx_ready) begin
			exp_q.push_back(cur_pay);
			accepted++;
			cur_pay = link_pkg::PAY_W'($random(seed));
		end
		if (rx_pop) begin
			popped++;
			if (exp_q.size() == 0) begin
				$display("%s: word %h came out with none expected", cur_name, rx_data);
				errs++;
			end else begin
				check_payload("rx_data", exp_q.pop_front(), rx_data);
			end
		end
		tick();
	endtask

	task automatic wait_link_up();
		int n;
		n = 0;
		while (link_up !== 1'b1 && n < UP_BOUND) begin
			check_bit("tx_ready_before_up", 1'b0, tx_ready);
			check_bit("rx_valid_before_up", 1'b0, rx_valid);
			tick();
			n++;
		end
		check_bit("link_up", 1'b1, link_up);
	endtask

	task automatic drain();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < 200) begin
			step(1'b0, 1'b1);
			n++;
		end
		check_count("words_left", 0, exp_q.size());
		repeat (QUIET_CYC) step(1'b0, 1'b1);  // idles must never surface as words
		check_bit("rx_valid_after_drain", 1'b0, rx_valid);
	endtask

	task automatic reset_mid_run();
		int n;
		n = 0;
		while (accepted < 4) step(1'b1, 1'b0);
		while (rx_valid !== 1'b1 && n < 50) begin
			step(1'b0, 1'b0);
			n++;
		end
		check_bit("rx_valid_before_reset", 1'b1, rx_valid);
		tb_rst = 1'b1;
		tick();
		tick();
		check_bit("link_up_in_reset", 1'b0, link_up);
		check_bit("rx_valid_in_reset", 1'b0, rx_valid);
		tick();
		tick();
		tb_rst = 1'b0;
		exp_q.delete();  // words in flight died with the reset
		wait_link_up();
	endtask

	task automatic report_test();
		if (errs == 0) begin
			pass_cnt++;
			$display("test %s ok", cur_name);
		end else begin
			fail_cnt++;
			$display("test %s had %0d errors", cur_name, errs);
		end
	endtask

	task automatic run_test(input int idx);
		int stall;
		int pop_limit;
		int n;
		cur_name = t_name[idx];
		errs     = 0;
		accepted = 0;
		cur_pay  = t_first[idx];
		if (t_rst[idx]) reset_mid_run();
		accepted = 0;
		popped   = 0;
		if (t_pop[idx] == POP_ALWAYS) begin
			while (accepted < t_words[idx]) step(($random(seed) & 3) != 0, 1'b1);  // random gaps
		end else begin
			pop_limit = t_words[idx] - link_pkg::RX_DEPTH;  // k pops buy k more words
			stall = 0;
			n = 0;
			while (stall < STALL_CYC) begin
				stall = tx_ready ? 0 : stall + 1;
				step(1'b1, t_pop[idx] == POP_THIRD && popped < pop_limit && n % 3 == 0);
				n++;
			end
			check_bit("tx_ready_when_full", 1'b0, tx_ready);
			check_count("accepted", t_words[idx], accepted);
		end
		drain();
		report_test();
	endtask

	// watchdog scaled from the table
	initial begin
		int limit;
		limit = 2000;
		for (int i = 0; i < N_TESTS; i++) limit += t_words[i] * 40;
		repeat (limit) @(posedge clk);
		$display("timeout: run did not finish within %0d cycles", limit);
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		int chk_errs;
		tx_data  = '0;
		tx_valid = 1'b0;
		rx_pop   = 1'b0;
		tb_rst   = 1'b0;
		wait (gen_rst === 1'b0);
		tick();
		cur_name = "bring_up";
		errs = 0;
		wait_link_up();
		report_test();
		for (int i = 0; i < N_TESTS; i++) run_test(i);
		chk_errs = dut.u_chk.err_cnt;
		$display("tests passed %0d failed %0d, assertion failures %0d",
			pass_cnt, fail_cnt, chk_errs);
		if (fail_cnt == 0 && chk_errs == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

//--- link_checker.sv
// bound assertions: credit bound, ready only with link up, no rx data before first link up
`timescale 1ns/10ps

module link_checker (
	input logic                          usrclk_i,
	input logic                          rst_i,
	input logic [link_pkg::CREDIT_W-1:0] credit_cnt_i,
	input logic                          tx_ready_i,
	input logic                          link_up_i,
	input logic                          rx_valid_i
);

	int   err_cnt = 0;     // assertion failures so far
	logic seen_up = 1'b0;  // link came up at least once since time zero

	always @(posedge usrclk_i) begin
		if (link_up_i) seen_up <= 1'b1;
	end

	credit_bound: assert property (@(posedge usrclk_i) disable iff (rst_i)
		credit_cnt_i <= link_pkg::CREDIT_W'(link_pkg::RX_DEPTH))
	else begin
		$error("credit count %0d above the receive depth", credit_cnt_i);
		err_cnt++;
	end

	ready_needs_up: assert property (@(posedge usrclk_i) disable iff (rst_i)
		tx_ready_i |-> link_up_i)
	else begin
		$error("tx ready high while the link is down");
		err_cnt++;
	end

	// buffer must stay empty until the first bring-up completes
	no_rx_before_up: assert property (@(posedge usrclk_i) disable iff (rst_i)
		!seen_up |-> !rx_valid_i)
	else begin
		$error("rx valid high before the link ever came up");
		err_cnt++;
	end

endmodule

// credit counter lives in the framer
bind link_top link_checker u_chk (
	.usrclk_i     (usrclk_i),
	.rst_i        (rst_i),
	.credit_cnt_i (u_framer.credit_cnt),
	.tx_ready_i   (tx_ready_o),
	.link_up_i    (link_up_o),
	.rx_valid_i   (rx_valid_o)
);

//--- link_tb_clkgen.sv
// testbench clock (8 ns period) and power-on reset held for 4 cycles
`timescale 1ns/10ps

module link_tb_clkgen (
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		forever #4 clk_o = ~clk_o;  // 125 MHz user clock
	end

	initial begin
		rst_o = 1'b1;
		repeat (4) @(posedge clk_o);
		#1 rst_o = 1'b0;  // released just after the 4th edge
	end

endmodule

//--- link_top.sv
// link top: reset sequencer, tx framer, transceiver wrapper, rx aligner and rx buffer
`timescale 1ns/10ps

module link_top (
	input  logic                       usrclk_i,
	input  logic                       rst_i,
	input  logic [link_pkg::PAY_W-1:0] tx_data_i,
	input  logic                       tx_valid_i,
	input  logic                       rx_pop_i,
	output logic                       tx_ready_o,
	output logic [link_pkg::PAY_W-1:0] rx_data_o,
	output logic                       rx_valid_o,
	output logic                       link_up_o
);

	logic                      gt_cpllreset;
	logic                      gt_txreset;
	logic                      gt_rxreset;
	logic                      gt_usrrdy;     // tx and rx user ready together
	logic                      cpll_locked;
	logic                      txresetdone;
	logic                      rxresetdone;
	logic                      aligned;
	logic [link_pkg::GT_W-1:0] gt_txdata;
	logic [link_pkg::GT_W-1:0] gt_rxdata;
	logic [link_pkg::GT_W-1:0] rx_word;
	logic                      rx_word_vld;
	logic                      credit_ret;    // local return path in loopback

	link_reset_seq u_seq (
		.usrclk_i (usrclk_i), .rst_i (rst_i),
		.cpll_locked_i (cpll_locked), .txresetdone_i (txresetdone),
		.rxresetdone_i (rxresetdone), .aligned_i (aligned),
		.cpllreset_o (gt_cpllreset), .txreset_o (gt_txreset), .rxreset_o (gt_rxreset),
		.usrrdy_o (gt_usrrdy), .link_up_o (link_up_o)
	);

	link_tx_framer u_framer (
		.usrclk_i (usrclk_i), .rst_i (rst_i), .link_up_i (link_up_o),
		.tx_data_i (tx_data_i), .tx_valid_i (tx_valid_i), .credit_ret_i (credit_ret),
		.tx_ready_o (tx_ready_o), .gt_txdata_o (gt_txdata)
	);

	gtx_wrap u_gtx (
		.usrclk_i (usrclk_i), .soft_reset_i (rst_i),
		.gt_cpllreset_i (gt_cpllreset), .gt_txreset_i (gt_txreset),
		.gt_rxreset_i (gt_rxreset), .gt_txusrrdy_i (gt_usrrdy), .gt_rxusrrdy_i (gt_usrrdy),
		.gt_txdata_i (gt_txdata), .gt_rxdata_o (gt_rxdata),
		.gt_cpll_locked_o (cpll_locked), .gt_txresetdone_o (txresetdone),
		.gt_rxresetdone_o (rxresetdone)
	);

	link_rx_aligner u_align (
		.usrclk_i (usrclk_i), .rst_i (rst_i), .gt_rxdata_i (gt_rxdata),
		.rx_word_o (rx_word), .rx_word_vld_o (rx_word_vld), .aligned_o (aligned)
	);

	link_rx_buffer u_rxbuf (
		.usrclk_i (usrclk_i), .rst_i (rst_i),
		.rx_word_i (rx_word), .rx_word_vld_i (rx_word_vld), .rx_pop_i (rx_pop_i),
		.rx_data_o (rx_data_o), .rx_valid_o (rx_valid_o), .credit_ret_o (credit_ret)
	);

endmodule

//--- link_rx_buffer.sv
// rx buffer: tag decode, payload fifo and credit return on pop
`timescale 1ns/10ps

module link_rx_buffer (
	input  logic                       usrclk_i,
	input  logic                       rst_i,
	input  logic [link_pkg::GT_W-1:0]  rx_word_i,
	input  logic                       rx_word_vld_i,
	input  logic                       rx_pop_i,
	output logic [link_pkg::PAY_W-1:0] rx_data_o,
	output logic                       rx_valid_o,
	output logic                       credit_ret_o
);

	localparam int PTR_W = $clog2(link_pkg::RX_DEPTH);

	logic [link_pkg::PAY_W-1:0] mem [link_pkg::RX_DEPTH];
	logic [PTR_W-1:0]           wr_ptr;
	logic [PTR_W-1:0]           rd_ptr;
	logic [PTR_W:0]             count;    // entries held, 0..RX_DEPTH
	link_pkg::link_tag_e        tag;
	logic                       wr_en;
	logic                       pop_ok;

	// idles and anything unknown are dropped here
	assign tag    = link_pkg::link_tag_e'(rx_word_i[link_pkg::GT_W-1 -: link_pkg::TAG_W]);
	assign wr_en  = rx_word_vld_i && (tag == link_pkg::TAG_DATA);
	assign pop_ok = rx_pop_i && rx_valid_o;  // pop ignored when empty

	// head of fifo straight to the user
	assign rx_valid_o = (count != '0);
	assign rx_data_o  = mem[rd_ptr];

	// storage, credits make sure a free slot exists
	always_ff @(posedge usrclk_i) begin
		if (wr_en) mem[wr_ptr] <= rx_word_i[link_pkg::PAY_W-1:0];
	end

	always_ff @(posedge usrclk_i) begin
		if (rst_i) begin
			wr_ptr       <= '0;
			rd_ptr       <= '0;
			count        <= '0;
			credit_ret_o <= 1'b0;
		end else begin
			if (wr_en) wr_ptr <= wr_ptr + 1'b1;   // power of two depth, wraps
			if (pop_ok) rd_ptr <= rd_ptr + 1'b1;
			case ({wr_en, pop_ok})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			credit_ret_o <= pop_ok;  // freed slot goes back to the framer
		end
	end

endmodule

//--- link_rx_aligner.sv
// rx word aligner: comma search over all bit offsets, lock and realigned output
`timescale 1ns/10ps

module link_rx_aligner (
	input  logic                      usrclk_i,
	input  logic                      rst_i,
	input  logic [link_pkg::GT_W-1:0] gt_rxdata_i,
	output logic [link_pkg::GT_W-1:0] rx_word_o,
	output logic                      rx_word_vld_o,
	output logic                      aligned_o
);

	localparam int OFF_W = $clog2(link_pkg::GT_W);

	logic [link_pkg::GT_W-1:0]             prev_q;     // last raw word
	logic [2*link_pkg::GT_W-1:0]           pair;       // prev then current, older bits on top
	logic                                  hit_any;
	logic [OFF_W-1:0]                      hit_off;    // lowest offset matching the comma
	logic [OFF_W-1:0]                      cand_off;   // offset being counted
	logic [OFF_W-1:0]                      lock_off;
	logic [$clog2(link_pkg::ALIGN_HITS)-1:0] hit_cnt;
	logic                                  locked;

	assign pair = {prev_q, gt_rxdata_i};

	// compare idle word against every 20 bit window
	always_comb begin
		hit_any = 1'b0;
		hit_off = '0;
		for (int k = link_pkg::GT_W - 1; k >= 0; k--) begin
			if (pair[2*link_pkg::GT_W-1-k -: link_pkg::GT_W] == link_pkg::IDLE_WORD) begin
				hit_any = 1'b1;
				hit_off = OFF_W'(k);  // lowest index wins
			end
		end
	end

	// lock search, only before lock
	always_ff @(posedge usrclk_i) begin
		if (rst_i) begin
			locked        <= 1'b0;
			hit_cnt       <= '0;
			cand_off      <= '0;
			lock_off      <= '0;
			rx_word_vld_o <= 1'b0;
		end else begin
			rx_word_vld_o <= locked;
			if (!locked) begin
				if (!hit_any) begin
					hit_cnt <= '0;  // run broken
				end else if (hit_off != cand_off || hit_cnt == '0) begin
					cand_off <= hit_off;  // new candidate, first hit
					hit_cnt  <= 1'b1;
				end else if (hit_cnt == link_pkg::ALIGN_HITS - 1) begin
					locked   <= 1'b1;
					lock_off <= cand_off;
				end else begin
					hit_cnt <= hit_cnt + 1'b1;
				end
			end
		end
	end

	// raw history and realigned word
	always_ff @(posedge usrclk_i) begin
		prev_q    <= gt_rxdata_i;
		rx_word_o <= pair[2*link_pkg::GT_W-1-lock_off -: link_pkg::GT_W];
	end

	assign aligned_o = locked;

endmodule

//--- link_tx_framer.sv
// tx framer: credit counter, data tagging and idle comma fill
`timescale 1ns/10ps

module link_tx_framer (
	input  logic                       usrclk_i,
	input  logic                       rst_i,
	input  logic                       link_up_i,
	input  logic [link_pkg::PAY_W-1:0] tx_data_i,
	input  logic                       tx_valid_i,
	input  logic                       credit_ret_i,   // one pulse per freed rx entry
	output logic                       tx_ready_o,
	output logic [link_pkg::GT_W-1:0]  gt_txdata_o
);

	logic [link_pkg::CREDIT_W-1:0] credit_cnt;  // free entries at the far buffer
	logic                          xfer;        // word accepted this cycle

	// accept only with link up and room at the receiver
	assign tx_ready_o = link_up_i && (credit_cnt != '0);
	assign xfer       = tx_valid_i && tx_ready_o;

	// credits
	// spend one per data word, regain one per return pulse
	// full pool again whenever the link is down
	always_ff @(posedge usrclk_i) begin
		if (rst_i || !link_up_i) begin
			credit_cnt <= link_pkg::CREDIT_W'(link_pkg::RX_DEPTH);
		end else begin
			case ({xfer, credit_ret_i})
				2'b10:   credit_cnt <= credit_cnt - 1'b1;
				2'b01:   credit_cnt <= credit_cnt + 1'b1;
				default: credit_cnt <= credit_cnt;  // none, or spend and return together
			endcase
		end
	end

	// line word out, one every cycle
	// idles keep the far aligner fed while there is no data
	always_ff @(posedge usrclk_i) begin
		if (xfer) begin
			gt_txdata_o <= {link_pkg::TAG_DATA, tx_data_i};
		end else begin
			gt_txdata_o <= link_pkg::IDLE_WORD;
		end
	end

endmodule

//--- link_reset_seq.sv
// bring-up fsm for pll, tx and rx resets, user ready and link up, with align timeout
`timescale 1ns/10ps

module link_reset_seq (
	input  logic usrclk_i,
	input  logic rst_i,
	input  logic cpll_locked_i,
	input  logic txresetdone_i,
	input  logic rxresetdone_i,
	input  logic aligned_i,
	output logic cpllreset_o,
	output logic txreset_o,
	output logic rxreset_o,
	output logic usrrdy_o,
	output logic link_up_o
);

	link_pkg::rst_state_e                       state;
	logic [$clog2(link_pkg::ALIGN_TIMEOUT)-1:0] tmo_cnt;  // cycles spent waiting for align

	always_ff @(posedge usrclk_i) begin
		if (rst_i) begin
			state       <= link_pkg::RS_PLL;
			cpllreset_o <= 1'b1;  // everything held in reset
			txreset_o   <= 1'b1;
			rxreset_o   <= 1'b1;
			usrrdy_o    <= 1'b0;
			link_up_o   <= 1'b0;
			tmo_cnt     <= '0;
		end else if (state != link_pkg::RS_PLL && !cpll_locked_i) begin
			// lost lock, start over from the pll
			state       <= link_pkg::RS_PLL;
			cpllreset_o <= 1'b1;
			txreset_o   <= 1'b1;
			rxreset_o   <= 1'b1;
			usrrdy_o    <= 1'b0;
			link_up_o   <= 1'b0;
		end else begin
			case (state)
				link_pkg::RS_PLL: begin
					if (cpllreset_o) cpllreset_o <= 1'b0;  // one cycle of pll reset
					else if (cpll_locked_i) begin
						state     <= link_pkg::RS_TX;
						txreset_o <= 1'b0;
					end
				end
				link_pkg::RS_TX: begin
					if (txresetdone_i) begin
						state     <= link_pkg::RS_RX;
						rxreset_o <= 1'b0;
					end
				end
				link_pkg::RS_RX: begin
					if (rxreset_o) rxreset_o <= 1'b0;  // end of a retry pulse
					else if (rxresetdone_i) begin
						state    <= link_pkg::RS_ALIGN;
						usrrdy_o <= 1'b1;
						tmo_cnt  <= '0;
					end
				end
				link_pkg::RS_ALIGN: begin
					if (aligned_i) begin
						state     <= link_pkg::RS_UP;
						link_up_o <= 1'b1;
					end else if (tmo_cnt == link_pkg::ALIGN_TIMEOUT - 1) begin
						// no comma lock, kick the rx side again
						state     <= link_pkg::RS_RX;
						rxreset_o <= 1'b1;
						usrrdy_o  <= 1'b0;
					end else begin
						tmo_cnt <= tmo_cnt + 1'b1;
					end
				end
				link_pkg::RS_UP: link_up_o <= 1'b1;  // stays up until lock loss or rst
				default: state <= link_pkg::RS_PLL;
			endcase
		end
	end

endmodule

//--- gtx_wrap.sv
// transceiver wrapper: behavioural loopback lane
`timescale 1ns/10ps

module gtx_wrap (
	input  logic                      usrclk_i,        // tx and rx user clock, same in loopback
	input  logic                      soft_reset_i,
	input  logic                      gt_cpllreset_i,
	input  logic                      gt_txreset_i,
	input  logic                      gt_rxreset_i,
	input  logic                      gt_txusrrdy_i,
	input  logic                      gt_rxusrrdy_i,
	input  logic [link_pkg::GT_W-1:0] gt_txdata_i,
	output logic [link_pkg::GT_W-1:0] gt_rxdata_o,
	output logic                      gt_cpll_locked_o,
	output logic                      gt_txresetdone_o,
	output logic                      gt_rxresetdone_o
);

	logic [$clog2(link_pkg::PLL_LOCK_CYC)-1:0] lock_cnt;
	logic                                      lock_q;
	logic [1:0]                                done_rst;  // bit 0 tx, bit 1 rx
	logic [1:0]                                done_q;
	logic [$clog2(link_pkg::RST_DONE_CYC)-1:0] done_cnt [2];
	logic [link_pkg::GT_W-1:0]                 lane_in;
	logic [link_pkg::GT_W-1:0]                 dly [link_pkg::LANE_LAT];
	logic [link_pkg::GT_W-1:0]                 dly_prev;  // word before the delay line tail
	logic [2*link_pkg::GT_W-1:0]               pair;

	// pll lock after a fixed count once its reset is released
	always_ff @(posedge usrclk_i) begin
		if (soft_reset_i || gt_cpllreset_i) begin
			lock_cnt <= '0;
			lock_q   <= 1'b0;
		end else if (lock_cnt == link_pkg::PLL_LOCK_CYC - 1) begin
			lock_q <= 1'b1;
		end else begin
			lock_cnt <= lock_cnt + 1'b1;
		end
	end

	// tx and rx resetdone, same delay, only counts while locked
	assign done_rst = {gt_rxreset_i, gt_txreset_i};
	always_ff @(posedge usrclk_i) begin
		for (int i = 0; i < 2; i++) begin
			if (soft_reset_i || done_rst[i] || !lock_q) begin
				done_cnt[i] <= '0;
				done_q[i]   <= 1'b0;
			end else if (done_cnt[i] == link_pkg::RST_DONE_CYC - 1) begin
				done_q[i] <= 1'b1;
			end else begin
				done_cnt[i] <= done_cnt[i] + 1'b1;
			end
		end
	end

	// serializer silent until tx side is up
	assign lane_in = (done_q[0] && gt_txusrrdy_i) ? gt_txdata_i : '0;

	always_ff @(posedge usrclk_i) begin
		if (soft_reset_i) begin
			for (int i = 0; i < link_pkg::LANE_LAT; i++) dly[i] <= '0;
			dly_prev <= '0;
		end else begin
			dly[0] <= lane_in;
			for (int i = 1; i < link_pkg::LANE_LAT; i++) dly[i] <= dly[i-1];
			dly_prev <= dly[link_pkg::LANE_LAT-1];
		end
	end

	// deserializer boundary sits LANE_SLIP bits into the older word
	assign pair        = {dly_prev, dly[link_pkg::LANE_LAT-1]};
	assign gt_rxdata_o = (done_q[1] && gt_rxusrrdy_i) ?
		pair[2*link_pkg::GT_W-1-link_pkg::LANE_SLIP -: link_pkg::GT_W] : '0;

	assign gt_cpll_locked_o = lock_q;
	assign gt_txresetdone_o = done_q[0];
	assign gt_rxresetdone_o = done_q[1];

endmodule

//--- link_pkg.sv
// link widths, word tags, idle comma, lane model timing and reset sequencer states
package link_pkg;

	// line word layout
	localparam int GT_W  = 20;           // parallel word to and from the transceiver
	localparam int PAY_W = 16;           // user payload
	localparam int TAG_W = 4;            // upper bits of every line word

	// word tags, upper TAG_W bits of a line word
	typedef enum logic [TAG_W-1:0] {
		TAG_IDLE = 4'b1100,               // comma fill
		TAG_DATA = 4'b0011                // user payload follows
	} link_tag_e;

	// odd weight (11 ones) so no rotation of the idle word equals itself
	localparam logic [PAY_W-1:0] COMMA_PAY = 16'h0f57;
	localparam logic [GT_W-1:0]  IDLE_WORD = {TAG_IDLE, COMMA_PAY};

	// receive side storage and credits
	localparam int RX_DEPTH = 8;         // fifo entries = initial credits
	localparam int CREDIT_W = 4;         // holds 0..RX_DEPTH

	// behavioural lane model
	localparam int LANE_LAT     = 3;     // register stages tx to rx
	localparam int LANE_SLIP    = 7;     // bit offset of the rx word boundary
	localparam int PLL_LOCK_CYC = 16;    // pll reset release to lock
	localparam int RST_DONE_CYC = 8;     // tx/rx reset release to resetdone

	// alignment
	localparam int ALIGN_HITS    = 4;    // commas in a row at one offset
	localparam int ALIGN_TIMEOUT = 128;  // sequencer gives up and resets rx

	// bring-up sequencer
	typedef enum logic [2:0] {RS_PLL, RS_TX, RS_RX, RS_ALIGN, RS_UP} rst_state_e;

endpackage
